// ==== compile.f ====
hw/hbm_pkg.sv
hw/dma_to_dram.sv
hw/dram_channel_mem.sv
hw/mem_subsys_top.sv
test/dma_to_dram_assert.sv
test/mem_subsys_tb.sv

// ==== hw/dma_to_dram.sv ====
// cache dma to dram channel bridge
// packs four write words into one beat, unpacks a read beat into four words
// blocking, one packet in flight
module dma_to_dram (
  input  logic                             core_clk,
  input  logic                             rst_n_i,

  input  logic                             dma_pkt_v_i,
  input  logic                             dma_pkt_write_i,
  input  logic [hbm_pkg::CH_ADDR_W_LP-1:0] dma_pkt_addr_i,
  output logic                             dma_pkt_yumi_o,

  input  logic [hbm_pkg::WORD_W_LP-1:0]    dma_wdata_i,
  input  logic                             dma_wdata_v_i,
  output logic                             dma_wdata_yumi_o,

  output logic [hbm_pkg::WORD_W_LP-1:0]    dma_rdata_o,
  output logic                             dma_rdata_v_o,
  input  logic                             dma_rdata_ready_i,

  output logic                             req_v_o,
  output logic                             req_write_o,
  output hbm_pkg::hbm_ch_addr_u            req_addr_o,
  output logic [hbm_pkg::BEAT_W_LP-1:0]    req_wdata_o,
  input  logic                             req_yumi_i,

  input  logic                             rd_v_i,
  input  logic [hbm_pkg::BEAT_W_LP-1:0]    rd_data_i
);

  import hbm_pkg::*;

  logic [2:0] state_r;
  logic [2:0] state_n;
  logic write_r;
  hbm_ch_addr_u addr_r;
  logic [BEAT_W_LP-1:0] beat_r;
  logic [WORD_IDX_W_LP-1:0] word_cnt_r;
  logic last_word;
  logic rdata_xfer;

  assign last_word = word_cnt_r == WORD_IDX_W_LP'(BLOCK_WORDS_LP - 1);
  assign rdata_xfer = dma_rdata_v_o & dma_rdata_ready_i;

  // cache side handshakes
  assign dma_pkt_yumi_o = (state_r == ST_IDLE_LP) & dma_pkt_v_i;
  assign dma_wdata_yumi_o = (state_r == ST_COLLECT_LP) & dma_wdata_v_i;
  assign dma_rdata_v_o = state_r == ST_SEND_LP;
  assign dma_rdata_o = beat_r[word_cnt_r*WORD_W_LP +: WORD_W_LP];

  // dram side
  assign req_v_o = state_r == ST_REQ_LP;
  assign req_write_o = write_r;
  assign req_addr_o = addr_r;
  assign req_wdata_o = beat_r;

  always_comb begin
    state_n = state_r;
    case (state_r)
      ST_IDLE_LP: begin
        if (dma_pkt_v_i) begin
          state_n = dma_pkt_write_i ? ST_COLLECT_LP : ST_REQ_LP;
        end
      end
      ST_COLLECT_LP: begin
        if (dma_wdata_v_i && last_word) begin
          state_n = ST_REQ_LP;
        end
      end
      ST_REQ_LP: begin
        // writes need no response
        if (req_yumi_i) begin
          state_n = write_r ? ST_IDLE_LP : ST_WAIT_LP;
        end
      end
      ST_WAIT_LP: begin
        if (rd_v_i) begin
          state_n = ST_SEND_LP;
        end
      end
      ST_SEND_LP: begin
        if (rdata_xfer && last_word) begin
          state_n = ST_IDLE_LP;
        end
      end
      default: begin
        state_n = ST_IDLE_LP;
      end
    endcase
  end

  // word counter wraps back to zero after the last word
  always_ff @(posedge core_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_r <= ST_IDLE_LP;
      word_cnt_r <= '0;
    end else begin
      state_r <= state_n;
      if (dma_wdata_yumi_o || rdata_xfer) begin
        word_cnt_r <= word_cnt_r + 1'b1;
      end
    end
  end

  always_ff @(posedge core_clk) begin
    if (dma_pkt_yumi_o) begin
      write_r <= dma_pkt_write_i;
      addr_r.byte_addr <= dma_pkt_addr_i;
    end
    // word 0 lands in the low bits
    if (dma_wdata_yumi_o) begin
      beat_r[word_cnt_r*WORD_W_LP +: WORD_W_LP] <= dma_wdata_i;
    end
    if ((state_r == ST_WAIT_LP) && rd_v_i) begin
      beat_r <= rd_data_i;
    end
  end

endmodule

// ==== hw/dram_channel_mem.sv ====
// behavioral dram channel
// block storage in row-major order, fixed read latency, one read pending at a time
module dram_channel_mem (
  input  logic                          core_clk,
  input  logic                          rst_n_i,

  input  logic                          req_v_i,
  input  logic                          req_write_i,
  input  hbm_pkg::hbm_ch_addr_u         req_addr_i,
  input  logic [hbm_pkg::BEAT_W_LP-1:0] req_wdata_i,
  output logic                          req_yumi_o,

  output logic                          rd_v_o,
  output logic [hbm_pkg::BEAT_W_LP-1:0] rd_data_o
);

  import hbm_pkg::*;

  logic [BEAT_W_LP-1:0] mem_r [BLOCKS_LP] = '{default: '0};
  logic [BLOCK_IDX_W_LP-1:0] blk_idx;
  logic [LAT_CNT_W_LP-1:0] lat_cnt_r;
  logic rd_pending;
  logic rd_take;

  // row, bank group, bank, column; byte offset dropped
  assign blk_idx = {
    req_addr_i.fld.ro,
    req_addr_i.fld.bg,
    req_addr_i.fld.ba,
    req_addr_i.fld.co
  };

  assign rd_pending = lat_cnt_r != '0;
  assign req_yumi_o = req_v_i & ~rd_pending;
  assign rd_take = req_yumi_o & ~req_write_i;

  // last cycle of the countdown
  assign rd_v_o = lat_cnt_r == LAT_CNT_W_LP'(1);

  always_ff @(posedge core_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      lat_cnt_r <= '0;
    end else if (rd_take) begin
      lat_cnt_r <= LAT_CNT_W_LP'(READ_LAT_LP);
    end else if (rd_pending) begin
      lat_cnt_r <= lat_cnt_r - 1'b1;
    end
  end

  // write lands in the accept cycle, read beat is held until rd_v_o
  always_ff @(posedge core_clk) begin
    if (req_yumi_o) begin
      if (req_write_i) begin
        mem_r[blk_idx] <= req_wdata_i;
      end else begin
        rd_data_o <= mem_r[blk_idx];
      end
    end
  end

endmodule

// ==== hw/hbm_pkg.sv ====
// hbm memory back end definitions
// widths, storage depth, read latency and the channel address word
package hbm_pkg;

  localparam int WORD_W_LP = 32;
  localparam int BLOCK_WORDS_LP = 4;
  localparam int BEAT_W_LP = WORD_W_LP * BLOCK_WORDS_LP;

  // channel address fields
  localparam int BYTE_OFF_W_LP = 4;
  localparam int CO_W_LP = 3;
  localparam int BA_W_LP = 1;
  localparam int BG_W_LP = 1;
  localparam int RO_W_LP = 3;
  localparam int CH_ADDR_W_LP = BG_W_LP + BA_W_LP + RO_W_LP + CO_W_LP + BYTE_OFF_W_LP;

  localparam int BLOCKS_LP = 256;
  localparam int READ_LAT_LP = 8;

  // derived counter and index widths
  localparam int WORD_IDX_W_LP = $clog2(BLOCK_WORDS_LP);
  localparam int BLOCK_IDX_W_LP = $clog2(BLOCKS_LP);
  localparam int LAT_CNT_W_LP = $clog2(READ_LAT_LP + 1);

  // bridge fsm states
  localparam logic [2:0] ST_IDLE_LP = 3'd0;
  localparam logic [2:0] ST_COLLECT_LP = 3'd1;
  localparam logic [2:0] ST_REQ_LP = 3'd2;
  localparam logic [2:0] ST_WAIT_LP = 3'd3;
  localparam logic [2:0] ST_SEND_LP = 3'd4;

  // flat byte address from the cache side, field view for the dram side
  typedef union packed {
    logic [CH_ADDR_W_LP-1:0] byte_addr;
    struct packed {
      logic [BG_W_LP-1:0] bg;
      logic [BA_W_LP-1:0] ba;
      logic [RO_W_LP-1:0] ro;
      logic [CO_W_LP-1:0] co;
      logic [BYTE_OFF_W_LP-1:0] byte_off;
    } fld;
  } hbm_ch_addr_u;

endpackage

// ==== hw/mem_subsys_top.sv ====
// two-channel memory back end
// reset synchronizer plus a bridge and dram channel for each of north and south
module mem_subsys_top (
  input  logic                             core_clk,
  input  logic                             arst_n_i,

  input  logic                             n_dma_pkt_v_i,
  input  logic                             n_dma_pkt_write_i,
  input  logic [hbm_pkg::CH_ADDR_W_LP-1:0] n_dma_pkt_addr_i,
  output logic                             n_dma_pkt_yumi_o,
  input  logic [hbm_pkg::WORD_W_LP-1:0]    n_dma_wdata_i,
  input  logic                             n_dma_wdata_v_i,
  output logic                             n_dma_wdata_yumi_o,
  output logic [hbm_pkg::WORD_W_LP-1:0]    n_dma_rdata_o,
  output logic                             n_dma_rdata_v_o,
  input  logic                             n_dma_rdata_ready_i,

  input  logic                             s_dma_pkt_v_i,
  input  logic                             s_dma_pkt_write_i,
  input  logic [hbm_pkg::CH_ADDR_W_LP-1:0] s_dma_pkt_addr_i,
  output logic                             s_dma_pkt_yumi_o,
  input  logic [hbm_pkg::WORD_W_LP-1:0]    s_dma_wdata_i,
  input  logic                             s_dma_wdata_v_i,
  output logic                             s_dma_wdata_yumi_o,
  output logic [hbm_pkg::WORD_W_LP-1:0]    s_dma_rdata_o,
  output logic                             s_dma_rdata_v_o,
  input  logic                             s_dma_rdata_ready_i
);

  import hbm_pkg::*;

  logic [2:0] rst_sync_r;
  logic rst_n;

  logic n_req_v;
  logic n_req_write;
  logic n_req_yumi;
  logic n_rd_v;
  hbm_ch_addr_u n_req_addr;
  logic [BEAT_W_LP-1:0] n_req_wdata;
  logic [BEAT_W_LP-1:0] n_rd_data;

  logic s_req_v;
  logic s_req_write;
  logic s_req_yumi;
  logic s_rd_v;
  hbm_ch_addr_u s_req_addr;
  logic [BEAT_W_LP-1:0] s_req_wdata;
  logic [BEAT_W_LP-1:0] s_rd_data;

  // three flops, assert immediately, release on the third edge
  always_ff @(posedge core_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rst_sync_r <= '0;
    end else begin
      rst_sync_r <= {rst_sync_r[1:0], 1'b1};
    end
  end

  assign rst_n = rst_sync_r[2];

  // north
  dma_to_dram i_bridge_n (
    .core_clk(core_clk), .rst_n_i(rst_n),
    .dma_pkt_v_i(n_dma_pkt_v_i), .dma_pkt_write_i(n_dma_pkt_write_i),
    .dma_pkt_addr_i(n_dma_pkt_addr_i), .dma_pkt_yumi_o(n_dma_pkt_yumi_o),
    .dma_wdata_i(n_dma_wdata_i), .dma_wdata_v_i(n_dma_wdata_v_i),
    .dma_wdata_yumi_o(n_dma_wdata_yumi_o),
    .dma_rdata_o(n_dma_rdata_o), .dma_rdata_v_o(n_dma_rdata_v_o),
    .dma_rdata_ready_i(n_dma_rdata_ready_i),
    .req_v_o(n_req_v), .req_write_o(n_req_write), .req_addr_o(n_req_addr),
    .req_wdata_o(n_req_wdata), .req_yumi_i(n_req_yumi),
    .rd_v_i(n_rd_v), .rd_data_i(n_rd_data)
  );

  dram_channel_mem i_chan_n (
    .core_clk(core_clk), .rst_n_i(rst_n),
    .req_v_i(n_req_v), .req_write_i(n_req_write), .req_addr_i(n_req_addr),
    .req_wdata_i(n_req_wdata), .req_yumi_o(n_req_yumi),
    .rd_v_o(n_rd_v), .rd_data_o(n_rd_data)
  );

  // south
  dma_to_dram i_bridge_s (
    .core_clk(core_clk), .rst_n_i(rst_n),
    .dma_pkt_v_i(s_dma_pkt_v_i), .dma_pkt_write_i(s_dma_pkt_write_i),
    .dma_pkt_addr_i(s_dma_pkt_addr_i), .dma_pkt_yumi_o(s_dma_pkt_yumi_o),
    .dma_wdata_i(s_dma_wdata_i), .dma_wdata_v_i(s_dma_wdata_v_i),
    .dma_wdata_yumi_o(s_dma_wdata_yumi_o),
    .dma_rdata_o(s_dma_rdata_o), .dma_rdata_v_o(s_dma_rdata_v_o),
    .dma_rdata_ready_i(s_dma_rdata_ready_i),
    .req_v_o(s_req_v), .req_write_o(s_req_write), .req_addr_o(s_req_addr),
    .req_wdata_o(s_req_wdata), .req_yumi_i(s_req_yumi),
    .rd_v_i(s_rd_v), .rd_data_i(s_rd_data)
  );

  dram_channel_mem i_chan_s (
    .core_clk(core_clk), .rst_n_i(rst_n),
    .req_v_i(s_req_v), .req_write_i(s_req_write), .req_addr_i(s_req_addr),
    .req_wdata_i(s_req_wdata), .req_yumi_o(s_req_yumi),
    .rd_v_o(s_rd_v), .rd_data_o(s_rd_data)
  );

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the memory back end testbench with verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f compile.f --top-module mem_subsys_tb -o sim_mem_subsys
./obj_dir/sim_mem_subsys 2>&1 | tee sim.log
if grep -q "all tests passed" sim.log; then
  echo "simulation PASS"
else
  echo "simulation FAIL"
  exit 1
fi

// ==== test/dma_to_dram_assert.sv ====
// bridge handshake checks
// yumi against valid, one packet in flight, read data held under back-pressure
module dma_to_dram_assert (
  input logic                          core_clk,
  input logic                          rst_n_i,
  input logic                          dma_pkt_v_i,
  input logic                          dma_pkt_write_i,
  input logic                          dma_pkt_yumi_o,
  input logic                          dma_wdata_v_i,
  input logic                          dma_wdata_yumi_o,
  input logic [hbm_pkg::WORD_W_LP-1:0] dma_rdata_o,
  input logic                          dma_rdata_v_o,
  input logic                          dma_rdata_ready_i,
  input logic                          req_v_o,
  input logic                          req_write_o,
  input logic                          req_yumi_i
);

  logic in_flight_r;
  logic [1:0] rd_cnt_r;
  logic [2:0] wr_left_r;
  logic rd_xfer;

  assign rd_xfer = dma_rdata_v_o & dma_rdata_ready_i;

  // packet ends at the write request or the fourth read word
  always_ff @(posedge core_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      in_flight_r <= 1'b0;
      rd_cnt_r <= '0;
      wr_left_r <= '0;
    end else begin
      if (dma_pkt_yumi_o) begin
        in_flight_r <= 1'b1;
      end else if ((req_v_o && req_yumi_i && req_write_o) || (rd_xfer && rd_cnt_r == 2'd3)) begin
        in_flight_r <= 1'b0;
      end
      if (rd_xfer) begin
        rd_cnt_r <= rd_cnt_r + 1'b1;
      end
      // words still owed by the write packet in flight
      if (dma_pkt_yumi_o && dma_pkt_write_i) begin
        wr_left_r <= 3'd4;
      end else if (dma_wdata_yumi_o && wr_left_r != '0) begin
        wr_left_r <= wr_left_r - 1'b1;
      end
    end
  end

  a_pkt_yumi: assert property (@(posedge core_clk) disable iff (!rst_n_i)
    dma_pkt_yumi_o |-> dma_pkt_v_i && !in_flight_r)
    else $error("packet taken without valid or while one is in flight");

  a_wdata_yumi: assert property (@(posedge core_clk) disable iff (!rst_n_i)
    dma_wdata_yumi_o |-> dma_wdata_v_i && wr_left_r != '0)
    else $error("write word taken without valid or outside a write packet");

  a_rdata_hold: assert property (@(posedge core_clk) disable iff (!rst_n_i)
    dma_rdata_v_o && !dma_rdata_ready_i |=> dma_rdata_v_o && $stable(dma_rdata_o))
    else $error("read word changed while stalled");

endmodule

bind dma_to_dram dma_to_dram_assert i_assert (
  .core_clk(core_clk), .rst_n_i(rst_n_i),
  .dma_pkt_v_i(dma_pkt_v_i), .dma_pkt_write_i(dma_pkt_write_i),
  .dma_pkt_yumi_o(dma_pkt_yumi_o),
  .dma_wdata_v_i(dma_wdata_v_i), .dma_wdata_yumi_o(dma_wdata_yumi_o),
  .dma_rdata_o(dma_rdata_o), .dma_rdata_v_o(dma_rdata_v_o),
  .dma_rdata_ready_i(dma_rdata_ready_i),
  .req_v_o(req_v_o), .req_write_o(req_write_o), .req_yumi_i(req_yumi_i)
);

// ==== test/mem_subsys_tb.sv ====
// memory back end testbench
// block writes and reads on both channels, checked against a word-level reference model
module mem_subsys_tb;

  import hbm_pkg::*;

  localparam int NUM_TESTS = 6;
  localparam int TEST_CYCLES = 400;
  localparam logic [CH_ADDR_W_LP-1:0] FIELD_FLIPS [5] = '{
    12'h000, 12'h800, 12'h400, 12'h080, 12'h010
  };

  logic core_clk = 1'b0;
  logic arst_n;
  logic [1:0] pkt_v;
  logic [1:0] pkt_write;
  logic [CH_ADDR_W_LP-1:0] pkt_addr [2];
  logic [WORD_W_LP-1:0] wdata [2];
  logic [1:0] wdata_v;
  logic [1:0] rdata_ready = 2'b11;
  wire [1:0] pkt_yumi;
  wire [1:0] wdata_yumi;
  wire [1:0] rdata_v;
  wire [WORD_W_LP-1:0] rdata [2];

  integer seed = 32'heae5d794;
  logic [31:0] rnd_ready;
  logic ready_random = 1'b0;
  logic [WORD_W_LP-1:0] ref_mem [2][BLOCKS_LP][BLOCK_WORDS_LP] = '{default: '0};
  logic [WORD_W_LP-1:0] exp_n [$];
  logic [WORD_W_LP-1:0] exp_s [$];
  int got_cnt [2] = '{0, 0};
  int cmp_errors = 0;
  int seq_errors = 0;
  int err_base = 0;
  int passed = 0;
  int test_num = 1;

  always #5 core_clk = ~core_clk;

  mem_subsys_top i_dut (
    .core_clk(core_clk), .arst_n_i(arst_n),
    .n_dma_pkt_v_i(pkt_v[0]), .n_dma_pkt_write_i(pkt_write[0]),
    .n_dma_pkt_addr_i(pkt_addr[0]), .n_dma_pkt_yumi_o(pkt_yumi[0]),
    .n_dma_wdata_i(wdata[0]), .n_dma_wdata_v_i(wdata_v[0]), .n_dma_wdata_yumi_o(wdata_yumi[0]),
    .n_dma_rdata_o(rdata[0]), .n_dma_rdata_v_o(rdata_v[0]), .n_dma_rdata_ready_i(rdata_ready[0]),
    .s_dma_pkt_v_i(pkt_v[1]), .s_dma_pkt_write_i(pkt_write[1]),
    .s_dma_pkt_addr_i(pkt_addr[1]), .s_dma_pkt_yumi_o(pkt_yumi[1]),
    .s_dma_wdata_i(wdata[1]), .s_dma_wdata_v_i(wdata_v[1]), .s_dma_wdata_yumi_o(wdata_yumi[1]),
    .s_dma_rdata_o(rdata[1]), .s_dma_rdata_v_o(rdata_v[1]), .s_dma_rdata_ready_i(rdata_ready[1])
  );

  function automatic string chan_name(input logic ch);
    return ch ? "south" : "north";
  endfunction

  // row, bank group, bank, column; byte offset ignored
  function automatic logic [7:0] block_index(input logic [CH_ADDR_W_LP-1:0] addr);
    return {addr[9:7], addr[11], addr[10], addr[6:4]};
  endfunction

  function automatic logic [WORD_W_LP-1:0] ref_word(input logic ch,
      input logic [CH_ADDR_W_LP-1:0] addr, input logic [1:0] idx);
    return ref_mem[ch][block_index(addr)][idx];
  endfunction

  function automatic logic [CH_ADDR_W_LP-1:0] random_addr();
    logic [31:0] r;
    r = $random(seed);
    return r[CH_ADDR_W_LP-1:0];
  endfunction

  task automatic random_words(output logic [BLOCK_WORDS_LP-1:0][WORD_W_LP-1:0] words);
    for (int i = 0; i < BLOCK_WORDS_LP; i++) begin
      words[i[1:0]] = $random(seed);
    end
  endtask

  task automatic send_packet(input logic ch, input logic is_write,
      input logic [CH_ADDR_W_LP-1:0] addr);
    @(negedge core_clk);
    pkt_v[ch] = 1'b1;
    pkt_write[ch] = is_write;
    pkt_addr[ch] = addr;
    @(posedge core_clk);
    while (!pkt_yumi[ch]) @(posedge core_clk);
    @(negedge core_clk);
    pkt_v[ch] = 1'b0;
  endtask

  task automatic write_block(input logic ch, input logic [CH_ADDR_W_LP-1:0] addr,
      input logic [BLOCK_WORDS_LP-1:0][WORD_W_LP-1:0] words);
    send_packet(ch, 1'b1, addr);
    for (int i = 0; i < BLOCK_WORDS_LP; i++) begin
      wdata[ch] = words[i[1:0]];
      wdata_v[ch] = 1'b1;
      @(posedge core_clk);
      while (!wdata_yumi[ch]) @(posedge core_clk);
      @(negedge core_clk);
    end
    wdata_v[ch] = 1'b0;
    for (int i = 0; i < BLOCK_WORDS_LP; i++) begin
      ref_mem[ch][block_index(addr)][i[1:0]] = words[i[1:0]];
    end
  endtask

  // expected words queued first, then wait until all have arrived
  task automatic read_block(input logic ch, input logic [CH_ADDR_W_LP-1:0] addr);
    for (int i = 0; i < BLOCK_WORDS_LP; i++) begin
      if (ch) exp_s.push_back(ref_word(ch, addr, i[1:0]));
      else exp_n.push_back(ref_word(ch, addr, i[1:0]));
    end
    send_packet(ch, 1'b0, addr);
    while (got_cnt[ch] != (ch ? exp_s.size() : exp_n.size())) @(posedge core_clk);
  endtask

  task automatic check_word(input logic ch, input logic [WORD_W_LP-1:0] got);
    logic [WORD_W_LP-1:0] exp;
    int exp_cnt;
    exp_cnt = ch ? exp_s.size() : exp_n.size();
    assert (got_cnt[ch] < exp_cnt) else begin
      $display("unexpected extra read word on %s channel at time %0t", chan_name(ch), $time);
      cmp_errors++;
    end
    if (got_cnt[ch] < exp_cnt) begin
      exp = ch ? exp_s[got_cnt[ch]] : exp_n[got_cnt[ch]];
      assert (got == exp) else begin
        $display("[ERROR] %0t: %s read word %0d is %h, expected %h",
                 $time, chan_name(ch), got_cnt[ch] % BLOCK_WORDS_LP, got, exp);
        cmp_errors++;
      end
      got_cnt[ch]++;
    end
  endtask

  task automatic report_test(input string name);
    if (cmp_errors + seq_errors == err_base) begin
      $display("test %0d %s: pass", test_num, name);
      passed++;
    end else begin
      $display("test %0d %s: FAIL", test_num, name);
    end
    err_base = cmp_errors + seq_errors;
    test_num++;
  endtask

  always @(negedge core_clk) begin
    if (ready_random) begin
      rnd_ready = $random(seed);
      rdata_ready = rnd_ready[1:0];
    end else begin
      rdata_ready = 2'b11;
    end
  end

  always @(posedge core_clk) begin
    if (rdata_v[0] && rdata_ready[0]) check_word(1'b0, rdata[0]);
    if (rdata_v[1] && rdata_ready[1]) check_word(1'b1, rdata[1]);
  end

  initial begin
    repeat (NUM_TESTS * TEST_CYCLES) @(posedge core_clk);
    $display("timeout: run did not finish within %0d cycles", NUM_TESTS * TEST_CYCLES);
    $display("tests failed");
    $finish;
  end

  initial begin
    logic [BLOCK_WORDS_LP-1:0][WORD_W_LP-1:0] words;
    logic [BLOCK_WORDS_LP-1:0][WORD_W_LP-1:0] burst [4];
    logic [CH_ADDR_W_LP-1:0] burst_addr [4];
    logic [CH_ADDR_W_LP-1:0] addr;
    logic [CH_ADDR_W_LP-1:0] base;
    arst_n = 1'b0;
    pkt_v = '0;
    pkt_write = '0;
    pkt_addr = '{default: '0};
    wdata = '{default: '0};
    wdata_v = '0;
    repeat (8) @(negedge core_clk);
    arst_n = 1'b1;
    repeat (4) @(negedge core_clk);
    assert ((pkt_yumi | wdata_yumi | rdata_v) == 2'b00) else begin
      $display("[ERROR] %0t: handshake outputs active after reset", $time);
      seq_errors++;
    end
    report_test("idle after reset");

    random_words(words);
    addr = random_addr();
    write_block(1'b0, addr, words);
    read_block(1'b0, addr);
    report_test("north write then read");

    addr = random_addr();
    random_words(words);
    write_block(1'b0, addr, words);
    random_words(words);
    write_block(1'b1, addr, words);
    read_block(1'b0, addr);
    read_block(1'b1, addr);
    report_test("channel independence");

    base = 12'h5a0;
    for (int f = 0; f < 5; f++) begin
      random_words(words);
      write_block(1'b0, base ^ FIELD_FLIPS[f[2:0]], words);
    end
    for (int f = 0; f < 5; f++) read_block(1'b0, base ^ FIELD_FLIPS[f[2:0]]);
    // offset bits only, lands on the base block
    random_words(words);
    write_block(1'b0, base | 12'h00c, words);
    read_block(1'b0, base);
    report_test("address fields and aliasing");

    for (int b = 0; b < 4; b++) begin
      random_words(burst[b[1:0]]);
      burst_addr[b[1:0]] = random_addr();
    end
    for (int b = 0; b < 4; b++) write_block(1'b0, burst_addr[b[1:0]], burst[b[1:0]]);
    ready_random = 1'b1;
    for (int b = 0; b < 4; b++) read_block(1'b0, burst_addr[b[1:0]]);
    ready_random = 1'b0;
    report_test("read back-pressure");

    read_block(1'b1, addr ^ 12'h080);
    report_test("unwritten block reads zero");

    $display("summary: %0d tests, %0d passed, %0d errors",
             NUM_TESTS, passed, cmp_errors + seq_errors);
    if (passed == NUM_TESTS && cmp_errors + seq_errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule
